// ==== logic/trellisPkg.sv ====
// trellis monitor package: address map, widths, DAC source codes and bus structs
package trellisPkg;

  // ------------------------------------------------------------
  // widths and counts
  // ------------------------------------------------------------
  localparam int SAMPLE_W          = 18;
  localparam int PHERR_W           = 10;
  localparam int PHOUT_W           = 8;
  localparam int INDEX_W           = 5;
  localparam int NUM_DAC           = 3;
  localparam int DAC_SEL_W         = 4;
  localparam int BER_W             = 16;
  localparam int APB_ADDR_W        = 12;
  localparam int APB_DATA_W        = 32;

  // legacy bit alignment against the decoder latency
  localparam int LEGACY_DELAY      = 14;
  localparam int LEGACY_FIFO_DEPTH = 16;
  localparam int LEGACY_PTR_W      = $clog2(LEGACY_FIFO_DEPTH);

  localparam logic [BER_W-1:0]   BER_WINDOW    = 16'hffff;

  // limiter rails, symmetric around zero
  localparam logic [PHOUT_W-1:0] PHOUT_POS_SAT = 8'h7f;
  localparam logic [PHOUT_W-1:0] PHOUT_NEG_SAT = 8'h81;

  // ------------------------------------------------------------
  // register map
  // ------------------------------------------------------------
  localparam logic [APB_ADDR_W-1:0] ADDR_BER     = 12'h100;
  localparam logic [APB_ADDR_W-1:0] ADDR_DAC_SEL = 12'h104;

  // DAC source select codes, anything else shows the phase error
  localparam logic [DAC_SEL_W-1:0] DAC_SRC_I     = 4'd0;
  localparam logic [DAC_SEL_W-1:0] DAC_SRC_Q     = 4'd1;
  localparam logic [DAC_SEL_W-1:0] DAC_SRC_PHERR = 4'd2;
  localparam logic [DAC_SEL_W-1:0] DAC_SRC_INDEX = 4'd3;

  // ------------------------------------------------------------
  // bus structs
  // ------------------------------------------------------------
  typedef struct packed {
    logic [APB_ADDR_W-1:0] paddr;
    logic                  psel;
    logic                  penable;
    logic                  pwrite;
    logic [APB_DATA_W-1:0] pwdata;
  } apbReq_t;

  typedef struct packed {
    logic [APB_DATA_W-1:0] prdata;
    logic                  pready;
    logic                  pslverr;
  } apbRsp_t;

  typedef struct packed {
    logic                valid;
    logic [SAMPLE_W-1:0] i;
    logic [SAMPLE_W-1:0] q;
  } iqSample_t;

  typedef struct packed {
    logic                sync;
    logic [SAMPLE_W-1:0] data;
  } dacOut_t;

  // errors sit in the upper half of the register word
  typedef struct packed {
    logic [BER_W-1:0] errors;
    logic [BER_W-1:0] count;
  } berStats_t;

  typedef logic [NUM_DAC-1:0][DAC_SEL_W-1:0] dacSel_t;

endpackage

// ==== logic/trellisApbRegs.sv ====
// APB register slave: DAC select fields, BER readout and BER restart strobe
module trellisApbRegs (
  input  logic                clk,
  input  logic                reset,
  input  trellisPkg::apbReq_t   apbReq,
  output trellisPkg::apbRsp_t   apbRsp,
  input  trellisPkg::berStats_t berStats,
  output trellisPkg::dacSel_t   dacSel,
  output logic                berRestart
);

  import trellisPkg::*;

  logic access;
  logic hitBer;
  logic hitDacSel;
  logic mapped;
  logic wrDacSel;

  // ------------------------------------------------------------
  // address decode
  // ------------------------------------------------------------
  // transfer completes in the access phase, no wait states
  assign access    = apbReq.psel && apbReq.penable;
  assign hitBer    = (apbReq.paddr == ADDR_BER);
  assign hitDacSel = (apbReq.paddr == ADDR_DAC_SEL);
  assign mapped    = hitBer || hitDacSel;
  assign wrDacSel  = access && apbReq.pwrite && hitDacSel;

  // any write to the BER register restarts the window
  assign berRestart = access && apbReq.pwrite && hitBer;

  // ------------------------------------------------------------
  // select registers
  // ------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (reset) begin
      dacSel <= '0;
    end else if (wrDacSel) begin
      dacSel <= apbReq.pwdata[NUM_DAC*DAC_SEL_W-1:0];
    end
  end

  // ------------------------------------------------------------
  // read data and response
  // ------------------------------------------------------------
  always_comb begin
    apbRsp.pready  = 1'b1;
    apbRsp.pslverr = access && !mapped;
    if (hitBer) begin
      apbRsp.prdata = berStats;
    end else if (hitDacSel) begin
      apbRsp.prdata = {{(APB_DATA_W-NUM_DAC*DAC_SEL_W){1'b0}}, dacSel};
    end else begin
      // unmapped, reads as zero
      apbRsp.prdata = '0;
    end
  end

endmodule

// ==== logic/berEstimator.sv ====
// BER estimator: legacy bit delay line, alignment FIFO, decision compare and counters
module berEstimator (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  symEn,
  input  logic                  legacyBit,
  input  logic                  decisionEn,
  input  logic                  decision,
  input  logic                  berRestart,
  output trellisPkg::berStats_t berStats
);

  import trellisPkg::*;

  logic [LEGACY_DELAY-1:0] legacyDelay;
  logic                    pushBit;
  logic                    legacyFifo [LEGACY_FIFO_DEPTH];
  logic [LEGACY_PTR_W:0]   wrPtr;
  logic [LEGACY_PTR_W:0]   rdPtr;
  logic                    fifoEmpty;
  logic                    fifoFull;
  logic                    fifoPush;
  logic                    fifoPop;
  logic                    legacyDelayed;

  // ------------------------------------------------------------
  // delay line, zeros until the first real bits come out
  // ------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (reset) begin
      legacyDelay <= '0;
    end else if (symEn) begin
      legacyDelay <= {legacyDelay[LEGACY_DELAY-2:0], legacyBit};
    end
  end

  assign pushBit = legacyDelay[LEGACY_DELAY-1];

  // ------------------------------------------------------------
  // alignment FIFO between symbol and decision strobes
  // ------------------------------------------------------------
  assign fifoEmpty = (wrPtr == rdPtr);
  assign fifoFull  = (wrPtr[LEGACY_PTR_W] != rdPtr[LEGACY_PTR_W]) &&
                     (wrPtr[LEGACY_PTR_W-1:0] == rdPtr[LEGACY_PTR_W-1:0]);

  // a pop frees the slot a same-cycle push lands in
  assign fifoPush = symEn && (!fifoFull || decisionEn);
  // empty with a push in flight, so the new bit bypasses the memory
  assign fifoPop  = decisionEn && (!fifoEmpty || symEn);

  assign legacyDelayed = fifoEmpty ? pushBit : legacyFifo[rdPtr[LEGACY_PTR_W-1:0]];

  always_ff @(posedge clk) begin
    if (fifoPush) begin
      legacyFifo[wrPtr[LEGACY_PTR_W-1:0]] <= pushBit;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      wrPtr <= '0;
      rdPtr <= '0;
    end else begin
      if (fifoPush) begin
        wrPtr <= wrPtr + 1'b1;
      end
      if (fifoPop) begin
        rdPtr <= rdPtr + 1'b1;
      end
    end
  end

  // ------------------------------------------------------------
  // counters, frozen once the window is used up
  // ------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (reset || berRestart) begin
      berStats.count  <= BER_WINDOW;
      berStats.errors <= '0;
    end else if (decisionEn && (berStats.count != '0)) begin
      berStats.count <= berStats.count - 1'b1;
      if (decision != legacyDelayed) begin
        berStats.errors <= berStats.errors + 1'b1;
      end
    end
  end

endmodule

// ==== logic/phaseErrorLimiter.sv ====
// phase error limiter: saturates the decoder phase error to a registered 8-bit word
module phaseErrorLimiter (
  input  logic                           clk,
  input  logic                           reset,
  input  logic                           phErrEn,
  input  logic [trellisPkg::PHERR_W-1:0] phaseError,
  output logic [trellisPkg::PHOUT_W-1:0] phErrOut,
  output logic                           phErrOutEn
);

  import trellisPkg::*;

  logic                       sign;
  logic [PHERR_W-PHOUT_W:0]   headBits;
  logic                       inRange;

  // value fits when the sign extends through the top bits
  assign sign     = phaseError[PHERR_W-1];
  assign headBits = phaseError[PHERR_W-1:PHOUT_W-1];
  assign inRange  = (headBits == '0) || (headBits == '1);

  always_ff @(posedge clk) begin
    if (reset) begin
      phErrOut   <= '0;
      phErrOutEn <= 1'b0;
    end else begin
      phErrOutEn <= phErrEn;
      if (phErrEn) begin
        if (inRange) begin
          phErrOut <= phaseError[PHOUT_W-1:0];
        end else begin
          phErrOut <= sign ? PHOUT_NEG_SAT : PHOUT_POS_SAT;
        end
      end
    end
  end

endmodule

// ==== logic/dacMonitorMux.sv ====
// DAC monitor mux: three registered channels, each picking one of four sources
module dacMonitorMux (
  input  logic                                    clk,
  input  logic                                    reset,
  input  trellisPkg::dacSel_t                     dacSel,
  input  trellisPkg::iqSample_t                   sample,
  input  logic [trellisPkg::PHOUT_W-1:0]          phErrOut,
  input  logic                                    phErrOutEn,
  input  logic                                    decisionEn,
  input  logic [trellisPkg::INDEX_W-1:0]          index,
  output trellisPkg::dacOut_t [trellisPkg::NUM_DAC-1:0] dac
);

  import trellisPkg::*;

  dacOut_t                srcI;
  dacOut_t                srcQ;
  dacOut_t                srcPhErr;
  dacOut_t                srcIndex;
  dacOut_t [NUM_DAC-1:0]  dacNext;

  // ------------------------------------------------------------
  // sources, left aligned in the DAC word
  // ------------------------------------------------------------
  assign srcI     = '{sync: sample.valid, data: sample.i};
  assign srcQ     = '{sync: sample.valid, data: sample.q};
  assign srcPhErr = '{sync: phErrOutEn,
                      data: {phErrOut, {(SAMPLE_W-PHOUT_W){1'b0}}}};
  // index kept positive with a leading zero
  assign srcIndex = '{sync: decisionEn,
                      data: {1'b0, index, {(SAMPLE_W-INDEX_W-1){1'b0}}}};

  always_comb begin
    for (int ch = 0; ch < NUM_DAC; ch++) begin
      case (dacSel[ch])
        DAC_SRC_I:     dacNext[ch] = srcI;
        DAC_SRC_Q:     dacNext[ch] = srcQ;
        DAC_SRC_INDEX: dacNext[ch] = srcIndex;
        default:       dacNext[ch] = srcPhErr;
      endcase
    end
  end

  // ------------------------------------------------------------
  // output registers
  // ------------------------------------------------------------
  always_ff @(posedge clk) begin
    for (int ch = 0; ch < NUM_DAC; ch++) begin
      dac[ch].data <= dacNext[ch].data;
      if (reset) begin
        dac[ch].sync <= 1'b0;
      end else begin
        dac[ch].sync <= dacNext[ch].sync;
      end
    end
  end

endmodule

// ==== logic/trellisMonitor.sv ====
// trellis monitor top: APB registers, BER estimator, phase limiter and DAC mux
module trellisMonitor (
  input  logic                                    clk,
  input  logic                                    reset,
  input  trellisPkg::apbReq_t                     apbReq,
  output trellisPkg::apbRsp_t                     apbRsp,
  input  logic                                    symEn,
  input  logic                                    legacyBit,
  input  logic                                    decisionEn,
  input  logic                                    decision,
  input  logic [trellisPkg::INDEX_W-1:0]          index,
  input  logic                                    phErrEn,
  input  logic [trellisPkg::PHERR_W-1:0]          phaseError,
  input  trellisPkg::iqSample_t                   sample,
  output trellisPkg::dacOut_t [trellisPkg::NUM_DAC-1:0] dac
);

  import trellisPkg::*;

  dacSel_t              dacSel;
  logic                 berRestart;
  berStats_t            berStats;
  logic [PHOUT_W-1:0]   phErrOut;
  logic                 phErrOutEn;

  // ------------------------------------------------------------
  // host side
  // ------------------------------------------------------------
  trellisApbRegs u_apbRegs (
    .clk        (clk),
    .reset      (reset),
    .apbReq     (apbReq),
    .apbRsp     (apbRsp),
    .berStats   (berStats),
    .dacSel     (dacSel),
    .berRestart (berRestart)
  );

  // ------------------------------------------------------------
  // processing
  // ------------------------------------------------------------
  berEstimator u_berEstimator (
    .clk        (clk),
    .reset      (reset),
    .symEn      (symEn),
    .legacyBit  (legacyBit),
    .decisionEn (decisionEn),
    .decision   (decision),
    .berRestart (berRestart),
    .berStats   (berStats)
  );

  phaseErrorLimiter u_phaseErrorLimiter (
    .clk        (clk),
    .reset      (reset),
    .phErrEn    (phErrEn),
    .phaseError (phaseError),
    .phErrOut   (phErrOut),
    .phErrOutEn (phErrOutEn)
  );

  // monitor outputs
  dacMonitorMux u_dacMonitorMux (
    .clk        (clk),
    .reset      (reset),
    .dacSel     (dacSel),
    .sample     (sample),
    .phErrOut   (phErrOut),
    .phErrOutEn (phErrOutEn),
    .decisionEn (decisionEn),
    .index      (index),
    .dac        (dac)
  );

endmodule

// ==== testbench/trellisMonitor_asserts.sv ====
// concurrent checks on the legacy FIFO flow, the APB ready line and the restart strobe
module trellisMonitor_asserts (
  input logic clk,
  input logic reset,
  input logic pushWhenFull,
  input logic popWhenEmpty,
  input logic pready,
  input logic restartPulse
);

  int failures = 0;

  // symbols may not run ahead of decisions by more than the FIFO depth
  noOverflow: assert property (@(posedge clk) disable iff (reset) !pushWhenFull)
    else begin
      $error("legacy FIFO push while full");
      failures++;
    end

  noUnderflow: assert property (@(posedge clk) disable iff (reset) !popWhenEmpty)
    else begin
      $error("legacy FIFO pop while empty");
      failures++;
    end

  // zero wait state slave
  alwaysReady: assert property (@(posedge clk) disable iff (reset) pready)
    else begin
      $error("pready dropped low");
      failures++;
    end

  restartOneCycle: assert property (@(posedge clk) disable iff (reset)
                                    restartPulse |=> !restartPulse)
    else begin
      $error("berRestart held for more than one cycle");
      failures++;
    end

endmodule

bind berEstimator trellisMonitor_asserts fifoChecks (
  .clk          (clk),
  .reset        (reset),
  .pushWhenFull (symEn && fifoFull && !decisionEn),
  .popWhenEmpty (decisionEn && fifoEmpty && !symEn),
  .pready       (1'b1),
  .restartPulse (1'b0)
);

bind trellisApbRegs trellisMonitor_asserts apbChecks (
  .clk          (clk),
  .reset        (reset),
  .pushWhenFull (1'b0),
  .popWhenEmpty (1'b0),
  .pready       (apbRsp.pready),
  .restartPulse (berRestart)
);

// ==== testbench/trellisMonitorTb.sv ====
// trellis monitor testbench: stimulus table, BER model, compare tasks, timeout and report
module trellisMonitorTb;

  import trellisPkg::*;

  typedef enum logic [2:0] {OP_BITS, OP_BER_RD, OP_WR, OP_RD, OP_PHERR, OP_SRC} opKind_t;

  // operands a, b, c and the expected value, meaning depends on op
  typedef struct packed {
    opKind_t     op;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] c;
    logic [31:0] exp;
  } testVec_t;

  logic                  clk = 1'b0;
  logic                  reset;
  apbReq_t               apbReq;
  apbRsp_t               apbRsp;
  logic                  symEn;
  logic                  legacyBit;
  logic                  decisionEn;
  logic                  decision;
  logic [INDEX_W-1:0]    index;
  logic                  phErrEn;
  logic [PHERR_W-1:0]    phaseError;
  iqSample_t             sample;
  dacOut_t [NUM_DAC-1:0] dac;

  testVec_t    tests[$];
  string       testNames[$];
  logic        legacyHist[$];
  logic [31:0] lfsr = 32'he2e3daf7;
  int          decCount = 0;
  berStats_t   modelBer;
  int          berErrors = 0;
  int          dacErrors = 0;
  int          apbErrors = 0;
  int          cycles = 0;

  trellisMonitor dut (.*);

  always #2 clk = ~clk;

  // ------------------------------------------------------------
  // stimulus helpers and reference model
  // ------------------------------------------------------------
  // Galois form of x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsrNext(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
  endfunction

  task automatic takeBit(output logic b);
    b = lfsr[0];
    lfsr = lfsrNext(lfsr);
  endtask

  task automatic addTest(input string name, input opKind_t op, input logic [31:0] a,
                         input logic [31:0] b, input logic [31:0] c, input logic [31:0] exp);
    testNames.push_back(name);
    tests.push_back('{op, a, b, c, exp});
  endtask

  // one cycle carrying a symbol, a decision or both
  task automatic sendStrobes(input logic withSym, input logic withDec, input logic flip,
                             input logic [INDEX_W-1:0] idx);
    logic legacy;
    logic aligned;
    logic dec;
    legacy  = 1'b0;
    aligned = 1'b0;
    dec     = 1'b0;
    if (withSym) begin
      takeBit(legacy);
      legacyHist.push_back(legacy);
    end
    if (withDec) begin
      // decision k meets legacy bit k-14, zeros before that
      if (decCount < LEGACY_DELAY) begin
        takeBit(dec);
      end else begin
        aligned = legacyHist[decCount-LEGACY_DELAY];
        dec = aligned ^ flip;
      end
      if (modelBer.count != 0) begin
        modelBer.count = modelBer.count - 1'b1;
        if (dec != aligned) begin
          modelBer.errors = modelBer.errors + 1'b1;
        end
      end
      decCount++;
    end
    @(posedge clk);
    symEn      <= withSym;
    legacyBit  <= legacy;
    decisionEn <= withDec;
    decision   <= dec;
    index      <= idx;
  endtask

  task automatic idleInputs();
    @(posedge clk);
    symEn        <= 1'b0;
    decisionEn   <= 1'b0;
    phErrEn      <= 1'b0;
    sample.valid <= 1'b0;
  endtask

  // setup then access phase, response taken once pready is seen
  task automatic apbAccess(input logic [APB_ADDR_W-1:0] addr, input logic write,
                           input logic [31:0] data, output apbRsp_t rsp);
    @(posedge clk);
    apbReq <= '{paddr: addr, psel: 1'b1, penable: 1'b0, pwrite: write, pwdata: data};
    @(posedge clk);
    apbReq.penable <= 1'b1;
    @(negedge clk);
    while (!apbRsp.pready) begin
      @(negedge clk);
    end
    rsp = apbRsp;
    @(posedge clk);
    apbReq <= '0;
  endtask

  // ------------------------------------------------------------
  // compare tasks
  // ------------------------------------------------------------
  task automatic checkBer(input string name, input berStats_t exp, input berStats_t act);
    if (act !== exp) begin
      $display("MISMATCH %s expected errors %0d count %0d actual errors %0d count %0d",
               name, exp.errors, exp.count, act.errors, act.count);
      berErrors++;
    end
  endtask

  task automatic checkDac(input string name, input dacOut_t exp, input dacOut_t act);
    if (act !== exp) begin
      $display("MISMATCH %s expected sync %b data %h actual sync %b data %h",
               name, exp.sync, exp.data, act.sync, act.data);
      dacErrors++;
    end
  endtask

  task automatic checkApb(input string name, input apbRsp_t exp, input apbRsp_t act);
    if (act !== exp) begin
      $display("MISMATCH %s expected prdata %h rdy %b err %b actual prdata %h rdy %b err %b",
               name, exp.prdata, exp.pready, exp.pslverr, act.prdata, act.pready, act.pslverr);
      apbErrors++;
    end
  endtask

  // ------------------------------------------------------------
  // watchdog
  // ------------------------------------------------------------
  initial begin
    @(posedge clk);
    while (cycles < tests.size() * 40) begin
      @(posedge clk);
      cycles++;
    end
    $display("timeout: run did not finish within %0d cycles", tests.size() * 40);
    $display("Some tests failed");
    $finish;
  end

  // ------------------------------------------------------------
  // table and main loop
  // ------------------------------------------------------------
  initial begin
    testVec_t tv;
    string    name;
    apbRsp_t  rsp;
    int       assertFails;
    reset      = 1'b1;
    apbReq     = '0;
    symEn      = 1'b0;
    legacyBit  = 1'b0;
    decisionEn = 1'b0;
    decision   = 1'b0;
    index      = '0;
    phErrEn    = 1'b0;
    phaseError = '0;
    sample     = '0;
    modelBer   = '{errors: '0, count: BER_WINDOW};

    addTest("berCount",       OP_BITS,   100, 0, 0, 0);
    addTest("berRead",        OP_BER_RD, 0, 0, 0, 0);
    addTest("berRestart",     OP_WR,     ADDR_BER, 0, 0, 0);
    addTest("berReadRestart", OP_BER_RD, 0, 0, 0, 0);
    addTest("berTen",         OP_BITS,   10, 0, 0, 0);
    addTest("berReadTen",     OP_BER_RD, 0, 0, 0, 0);
    addTest("selPhErr",       OP_WR,     ADDR_DAC_SEL, {24'h0, DAC_SRC_I, DAC_SRC_PHERR}, 0, 0);
    addTest("phErrPos300",    OP_PHERR,  300, 0, 0, 32'h7f);
    addTest("phErrPos127",    OP_PHERR,  127, 0, 0, 32'h7f);
    addTest("phErrPos128",    OP_PHERR,  128, 0, 0, 32'h7f);
    addTest("phErrNeg128",    OP_PHERR,  -128, 0, 0, 32'h80);
    addTest("phErrNeg129",    OP_PHERR,  -129, 0, 0, 32'h81);
    addTest("phErrNeg512",    OP_PHERR,  -512, 0, 0, 32'h81);
    addTest("selIqIndex",     OP_WR,     ADDR_DAC_SEL,
            {20'h0, DAC_SRC_INDEX, DAC_SRC_Q, DAC_SRC_I}, 0, 0);
    addTest("srcFirst",       OP_SRC,    18'h2abcd, 18'h15432, 5, 0);
    addTest("srcSecond",      OP_SRC,    18'h00001, 18'h3ffff, 31, 0);
    addTest("selReadBack",    OP_RD,     ADDR_DAC_SEL, 0, 0, 32'h310);
    addTest("badWrite",       OP_WR,     12'h200, 32'h0000_0fff, 1, 0);
    addTest("badRead",        OP_RD,     12'h200, 0, 1, 0);
    addTest("selUnchanged",   OP_RD,     ADDR_DAC_SEL, 0, 0, 32'h310);
    addTest("berAfterSrc",    OP_BER_RD, 0, 0, 0, 0);

    repeat (8) @(posedge clk);
    reset <= 1'b0;

    for (int t = 0; t < tests.size(); t++) begin
      tv   = tests[t];
      name = testNames[t];
      case (tv.op)
        OP_BITS: begin
          // symbols lead by a full FIFO then drain, flipped decisions at chosen positions
          for (int n = 0; n < tv.a + LEGACY_FIFO_DEPTH; n++) begin
            sendStrobes(n < tv.a, n >= LEGACY_FIFO_DEPTH,
                        ((n - LEGACY_FIFO_DEPTH) % 7) == 3, '0);
          end
          idleInputs();
        end
        OP_BER_RD: begin
          apbAccess(ADDR_BER, 1'b0, '0, rsp);
          checkBer(name, modelBer, rsp.prdata);
        end
        OP_WR: begin
          apbAccess(tv.a[APB_ADDR_W-1:0], 1'b1, tv.b, rsp);
          if (tv.a[APB_ADDR_W-1:0] == ADDR_BER) begin
            modelBer = '{errors: '0, count: BER_WINDOW};
          end
          // read data undefined on a write
          rsp.prdata = '0;
          checkApb(name, '{prdata: '0, pready: 1'b1, pslverr: tv.c[0]}, rsp);
        end
        OP_RD: begin
          apbAccess(tv.a[APB_ADDR_W-1:0], 1'b0, '0, rsp);
          checkApb(name, '{prdata: tv.exp, pready: 1'b1, pslverr: tv.c[0]}, rsp);
        end
        OP_PHERR: begin
          @(posedge clk);
          phErrEn    <= 1'b1;
          phaseError <= tv.a[PHERR_W-1:0];
          idleInputs();
          // limiter stage plus DAC register
          @(posedge clk);
          @(negedge clk);
          checkDac(name, '{sync: 1'b1, data: {tv.exp[PHOUT_W-1:0], 10'h000}}, dac[0]);
        end
        default: begin
          sendStrobes(1'b1, 1'b1, 1'b0, tv.c[INDEX_W-1:0]);
          sample <= '{valid: 1'b1, i: tv.a[SAMPLE_W-1:0], q: tv.b[SAMPLE_W-1:0]};
          idleInputs();
          @(negedge clk);
          checkDac(name, '{sync: 1'b1, data: tv.a[SAMPLE_W-1:0]}, dac[0]);
          checkDac(name, '{sync: 1'b1, data: tv.b[SAMPLE_W-1:0]}, dac[1]);
          checkDac(name, '{sync: 1'b1, data: {1'b0, tv.c[INDEX_W-1:0], 12'h000}}, dac[2]);
        end
      endcase
    end

    assertFails = dut.u_berEstimator.fifoChecks.failures + dut.u_apbRegs.apbChecks.failures;
    $display("errors: ber %0d dac %0d apb %0d assertions %0d",
             berErrors, dacErrors, apbErrors, assertFails);
    if (berErrors + dacErrors + apbErrors + assertFails == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

// ==== trellisMonitor.f ====
logic/trellisPkg.sv
logic/trellisApbRegs.sv
logic/berEstimator.sv
logic/phaseErrorLimiter.sv
logic/dacMonitorMux.sv
logic/trellisMonitor.sv
testbench/trellisMonitor_asserts.sv
testbench/trellisMonitorTb.sv

// ==== Bender.yml ====
package:
  name: trellis_monitor

sources:
  - logic/trellisPkg.sv
  - logic/trellisApbRegs.sv
  - logic/berEstimator.sv
  - logic/phaseErrorLimiter.sv
  - logic/dacMonitorMux.sv
  - logic/trellisMonitor.sv
  - target: test
    files:
      - testbench/trellisMonitor_asserts.sv
      - testbench/trellisMonitorTb.sv
